//--- verilog/swg_settings.svh
//************************************************************
// sliding window generator size macros
// image, kernel, element width and cyclic buffer depth
//************************************************************
`ifndef SWG_SETTINGS_SVH
`define SWG_SETTINGS_SVH

// input feature map height in pixels
`define SWG_IFM_H 6
// input feature map width in pixels
`define SWG_IFM_W 6

// channel elements per pixel, the innermost (simd) loop
`define SWG_IFM_C 2

// square kernel edge, stride and dilation fixed at 1
`define SWG_K 3

// bits per data element
`define SWG_ELEM_W 8

// power of two, holds (K-1) image rows plus K pixels of one row
`define SWG_BUF_DEPTH 32

`endif

//--- verilog/swg_pkg.sv
//************************************************************
// shared types of the sliding window generator
// element, index, address and increment vectors
// loop controller state encoding
//************************************************************
`default_nettype none

`include "swg_settings.svh"

package swg_pkg;

    // one data element of the stream
    typedef logic [`SWG_ELEM_W-1:0] elem_t;

    // absolute element index within a frame
    // one extra bit on top keeps it signed
    typedef logic signed [$clog2(`SWG_IFM_H * `SWG_IFM_W * `SWG_IFM_C + 1):0] idx_t;

    // cyclic buffer address, low bits of an index
    typedef logic [$clog2(`SWG_BUF_DEPTH)-1:0] addr_t;

    // signed step applied to a read index
    typedef logic signed [$bits(idx_t)-1:0] incr_t;

    // which loop level the next read step belongs to
    // start means the frame wraps back to element 0
    typedef enum logic [2:0] {
        STATE_START,
        STATE_LOOP_SIMD,
        STATE_LOOP_KW,
        STATE_LOOP_KH,
        STATE_LOOP_W,
        STATE_LOOP_H
    } state_e;

endpackage

`default_nettype wire

//--- verilog/swg_controller.sv
//************************************************************
// nested loop controller for the im2col read sequence
// gives the read step after each read and the step
// from one window base to the next
//************************************************************
`default_nettype none

`include "swg_settings.svh"

module swg_controller import swg_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  advance,
    output incr_t addr_incr,
    output incr_t tail_incr
);

    // output feature map size
    localparam int OFM_H = `SWG_IFM_H - `SWG_K + 1;
    localparam int OFM_W = `SWG_IFM_W - `SWG_K + 1;
    // elements in one image row
    localparam int ROW = `SWG_IFM_W * `SWG_IFM_C;
    // offset of a window's last element from its first one
    localparam int SPAN = (`SWG_K - 1) * ROW + `SWG_K * `SWG_IFM_C - 1;

    // steps inside a window
    localparam int HEAD_INCR_SIMD = 1;
    localparam int HEAD_INCR_KW = 1;
    // jump from the end of one kernel row to the start of the next
    localparam int HEAD_INCR_KH = ROW - `SWG_K * `SWG_IFM_C + 1;

    // window base steps, next pixel or next image row
    localparam int TAIL_INCR_W = `SWG_IFM_C;
    localparam int TAIL_INCR_H = `SWG_K * `SWG_IFM_C;
    // back from the last window base to element 0
    localparam int TAIL_INCR_LAST = -((OFM_H - 1) * ROW + (OFM_W - 1) * `SWG_IFM_C);

    // from a window's last element to the next window's first
    localparam int HEAD_INCR_W = TAIL_INCR_W - SPAN;
    localparam int HEAD_INCR_H = TAIL_INCR_H - SPAN;
    localparam int HEAD_INCR_LAST = TAIL_INCR_LAST - SPAN;

    // wide enough for any loop count plus a sign bit
    localparam int CNT_W = $clog2(OFM_H + OFM_W + `SWG_K + `SWG_IFM_C) + 1;
    typedef logic signed [CNT_W-1:0] cnt_t;

    // counters hold remaining iterations minus one, last pass at -1
    localparam cnt_t LOAD_H = cnt_t'(OFM_H - 2);
    localparam cnt_t LOAD_W = cnt_t'(OFM_W - 2);
    localparam cnt_t LOAD_KH = cnt_t'(`SWG_K - 2);
    localparam cnt_t LOAD_KW = cnt_t'(`SWG_K - 2);
    localparam cnt_t LOAD_SIMD = cnt_t'(`SWG_IFM_C - 2);

    state_e state;
    cnt_t   cnt_h;
    cnt_t   cnt_w;
    cnt_t   cnt_kh;
    cnt_t   cnt_kw;
    cnt_t   cnt_simd;
    cnt_t   h_nxt;
    cnt_t   w_nxt;
    cnt_t   kh_nxt;
    cnt_t   kw_nxt;
    cnt_t   simd_nxt;

    // innermost loop that still has iterations left
    function automatic state_e step_level(cnt_t s, cnt_t kw, cnt_t kh, cnt_t w, cnt_t h);
        if (s >= 0) begin
            return STATE_LOOP_SIMD;
        end else if (kw >= 0) begin
            return STATE_LOOP_KW;
        end else if (kh >= 0) begin
            return STATE_LOOP_KH;
        end else if (w >= 0) begin
            return STATE_LOOP_W;
        end else if (h >= 0) begin
            return STATE_LOOP_H;
        end
        return STATE_START;
    endfunction

    // read step for the current position
    always_comb begin
        case (state)
            STATE_LOOP_SIMD: addr_incr = incr_t'(HEAD_INCR_SIMD);
            STATE_LOOP_KW:   addr_incr = incr_t'(HEAD_INCR_KW);
            STATE_LOOP_KH:   addr_incr = incr_t'(HEAD_INCR_KH);
            STATE_LOOP_W:    addr_incr = incr_t'(HEAD_INCR_W);
            STATE_LOOP_H:    addr_incr = incr_t'(HEAD_INCR_H);
            STATE_START:     addr_incr = incr_t'(HEAD_INCR_LAST);
            default:         addr_incr = '0;
        endcase
    end

    // window base step, taken by the scheduler on a window's last read
    assign tail_incr = (cnt_w >= 0) ? incr_t'(TAIL_INCR_W) :
                       (cnt_h >= 0) ? incr_t'(TAIL_INCR_H) :
                                      incr_t'(TAIL_INCR_LAST);

    // nested countdown, an outer loop steps when the inner one wraps
    always_comb begin
        h_nxt = cnt_h;
        w_nxt = cnt_w;
        kh_nxt = cnt_kh;
        kw_nxt = cnt_kw;
        simd_nxt = cnt_simd;
        if (cnt_simd >= 0) begin
            simd_nxt = cnt_simd - cnt_t'(1);
        end else begin
            simd_nxt = LOAD_SIMD;
            if (cnt_kw >= 0) begin
                kw_nxt = cnt_kw - cnt_t'(1);
            end else begin
                kw_nxt = LOAD_KW;
                if (cnt_kh >= 0) begin
                    kh_nxt = cnt_kh - cnt_t'(1);
                end else begin
                    kh_nxt = LOAD_KH;
                    if (cnt_w >= 0) begin
                        w_nxt = cnt_w - cnt_t'(1);
                    end else begin
                        w_nxt = LOAD_W;
                        // frame wraps when h is spent
                        h_nxt = (cnt_h >= 0) ? cnt_h - cnt_t'(1) : LOAD_H;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= step_level(LOAD_SIMD, LOAD_KW, LOAD_KH, LOAD_W, LOAD_H);
            cnt_h <= LOAD_H;
            cnt_w <= LOAD_W;
            cnt_kh <= LOAD_KH;
            cnt_kw <= LOAD_KW;
            cnt_simd <= LOAD_SIMD;
        end else if (advance) begin
            // state follows the counters of the next position
            state <= step_level(simd_nxt, kw_nxt, kh_nxt, w_nxt, h_nxt);
            cnt_h <= h_nxt;
            cnt_w <= w_nxt;
            cnt_kh <= kh_nxt;
            cnt_kw <= kw_nxt;
            cnt_simd <= simd_nxt;
        end
    end

endmodule

`default_nettype wire

//--- verilog/swg_cyclic_buffer.sv
//************************************************************
// cyclic window buffer, single clock RAM
// one write port, one registered read port
//************************************************************
`default_nettype none

`include "swg_settings.svh"

module swg_cyclic_buffer import swg_pkg::*; (
    input  logic  clk,
    input  logic  write_enable,
    input  addr_t write_addr,
    input  elem_t data_in,
    input  logic  read_enable,
    input  addr_t read_addr,
    output elem_t data_out
);

    // holds the current window span plus a few lookahead elements
    elem_t ram [`SWG_BUF_DEPTH];

    // read sees the old word when both ports hit one address
    always_ff @(posedge clk) begin
        if (read_enable) begin
            data_out <= ram[read_addr];
        end
        if (write_enable) begin
            ram[write_addr] <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/swg_scheduler.sv
//************************************************************
// write and read scheduling of the window buffer
// input gating by occupancy, read issue, window base update
// frame completion and index restart
//************************************************************
`default_nettype none

`include "swg_settings.svh"

module swg_scheduler import swg_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  incr_t addr_incr,
    input  incr_t tail_incr,
    output logic  advance,
    output logic  write_enable,
    output addr_t write_addr,
    output logic  read_enable,
    output addr_t read_addr,
    output logic  out_valid,
    output logic  frame_done
);

    localparam int OFM_H = `SWG_IFM_H - `SWG_K + 1;
    localparam int OFM_W = `SWG_IFM_W - `SWG_K + 1;
    // elements per input frame
    localparam int FRAME_LEN = `SWG_IFM_H * `SWG_IFM_W * `SWG_IFM_C;
    // reads per window
    localparam int WIN_LEN = `SWG_K * `SWG_K * `SWG_IFM_C;
    // windows per frame
    localparam int N_WIN = OFM_H * OFM_W;
    localparam int ADDR_W = $bits(addr_t);
    localparam int RC_W = $clog2(WIN_LEN);
    localparam int WL_W = $clog2(N_WIN + 1);

    localparam logic [RC_W-1:0] WIN_LAST = RC_W'(WIN_LEN - 1);
    localparam logic [WL_W-1:0] WIN_COUNT = WL_W'(N_WIN);

    // elements written so far in this frame
    idx_t wr_idx;
    // index of the next element to read
    idx_t read_idx;
    // first element of the current window
    idx_t window_base;
    // reads done in the current window
    logic [RC_W-1:0] win_rd_cnt;
    // windows not yet finished in this frame
    logic [WL_W-1:0] windows_left;

    logic frame_open;
    logic buf_room;
    logic last_in_window;
    logic last_in_frame;

    // frame not yet fully written
    assign frame_open = (wr_idx < idx_t'(FRAME_LEN));
    // a write must not overwrite anything at or after window_base
    assign buf_room = (wr_idx < window_base + idx_t'(`SWG_BUF_DEPTH));
    assign in_ready = frame_open && buf_room;

    assign write_enable = in_valid && in_ready;
    assign write_addr = wr_idx[ADDR_W-1:0];

    // read as soon as the element is in the buffer
    // all indices are back at 0 once the frame is done, so reads stop there
    assign read_enable = (wr_idx > read_idx);
    assign read_addr = read_idx[ADDR_W-1:0];
    assign advance = read_enable;

    assign last_in_window = (win_rd_cnt == WIN_LAST);
    assign last_in_frame = last_in_window && (windows_left == WL_W'(1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_idx <= '0;
            read_idx <= '0;
            window_base <= '0;
            win_rd_cnt <= '0;
            windows_left <= WIN_COUNT;
            out_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // data leaves the RAM one cycle after the read
            out_valid <= read_enable;
            frame_done <= read_enable && last_in_frame;
            if (write_enable) begin
                wr_idx <= wr_idx + idx_t'(1);
            end
            if (read_enable) begin
                read_idx <= read_idx + addr_incr;
                if (last_in_window) begin
                    win_rd_cnt <= '0;
                    window_base <= window_base + tail_incr;
                    windows_left <= windows_left - WL_W'(1);
                end else begin
                    win_rd_cnt <= win_rd_cnt + RC_W'(1);
                end
                // final read restarts the write and window counts
                // read_idx and window_base reach 0 through the last controller steps
                if (last_in_frame) begin
                    wr_idx <= '0;
                    windows_left <= WIN_COUNT;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/swg_top.sv
//************************************************************
// sliding window generator top level
// loop controller, scheduler and cyclic buffer
//************************************************************
`default_nettype none

module swg_top import swg_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    input  elem_t in_data,
    output logic  in_ready,
    output logic  out_valid,
    output elem_t out_data,
    output logic  frame_done
);

    // read steps from the controller
    incr_t addr_incr;
    incr_t tail_incr;
    // one controller step per buffer read
    logic  advance;

    // buffer ports driven by the scheduler
    logic  write_enable;
    addr_t write_addr;
    logic  read_enable;
    addr_t read_addr;

    swg_controller swg_controller_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance   (advance),
        .addr_incr (addr_incr),
        .tail_incr (tail_incr)
    );

    swg_scheduler swg_scheduler_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .addr_incr    (addr_incr),
        .tail_incr    (tail_incr),
        .advance      (advance),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .read_enable  (read_enable),
        .read_addr    (read_addr),
        .out_valid    (out_valid),
        .frame_done   (frame_done)
    );

    // input data goes straight into the RAM write port
    swg_cyclic_buffer swg_cyclic_buffer_i (
        .clk          (clk),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .data_in      (in_data),
        .read_enable  (read_enable),
        .read_addr    (read_addr),
        .data_out     (out_data)
    );

endmodule

`default_nettype wire

//--- dv/swg_assertions.sv
//************************************************************
// concurrent checks on the window generator top level
// reset quiet outputs, read latency, write gating, frame end
//************************************************************
`default_nettype none

module swg_assertions (
    input logic clk,
    input logic rst_n,
    input logic in_ready,
    input logic write_enable,
    input logic read_enable,
    input logic out_valid,
    input logic frame_done
);

    timeunit 1ns;
    timeprecision 100ps;

    // number of failed checks
    int fail_count = 0;

    // outputs stay quiet one cycle into and right after reset
    quiet_after_reset: assert property (@(posedge clk) !rst_n |=> !out_valid && !frame_done)
        else begin
            fail_count++;
            $error("out_valid or frame_done high after a reset cycle");
        end

    // buffer read shows up on out_valid one cycle later
    read_gives_output: assert property (@(posedge clk) disable iff (!rst_n)
        read_enable |=> out_valid)
        else begin
            fail_count++;
            $error("buffer read not followed by out_valid");
        end

    // and never without a read before it
    output_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(read_enable))
        else begin
            fail_count++;
            $error("out_valid without a buffer read one cycle earlier");
        end

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !in_ready |-> !write_enable)
        else begin
            fail_count++;
            $error("buffer written while in_ready low");
        end

    // frame end marks the last element
    done_with_output: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> out_valid)
        else begin
            fail_count++;
            $error("frame_done without out_valid");
        end

endmodule

bind swg_top swg_assertions swg_assertions_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_ready     (in_ready),
    .write_enable (write_enable),
    .read_enable  (read_enable),
    .out_valid    (out_valid),
    .frame_done   (frame_done)
);

`default_nettype wire

//--- dv/swg_tb.sv
//************************************************************
// testbench for the sliding window generator
// clock, reset, im2col reference model and output monitor
// directed tests, watchdog and result summary
//************************************************************
`default_nettype none

`include "swg_settings.svh"

module swg_tb import swg_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 10;
    localparam int OFM_H = `SWG_IFM_H - `SWG_K + 1;
    localparam int OFM_W = `SWG_IFM_W - `SWG_K + 1;
    localparam int FRAME_LEN = `SWG_IFM_H * `SWG_IFM_W * `SWG_IFM_C;
    // every window of a frame in im2col order
    localparam int OUTS = OFM_H * OFM_W * `SWG_K * `SWG_K * `SWG_IFM_C;
    // frames over all tests with the aborted one counted in full
    localparam int N_FRAMES = 7;
    localparam int FRAME_TIMEOUT = (FRAME_LEN + OUTS) * 4;
    localparam int WATCHDOG_CYCLES = N_FRAMES * FRAME_TIMEOUT;
    localparam int MAX_GAP = 3;

    logic  clk;
    logic  rst_n;
    logic  in_valid;
    elem_t in_data;
    logic  in_ready;
    logic  out_valid;
    elem_t out_data;
    logic  frame_done;

    int    seed = 66;
    // input frame being sent and the expected output stream
    elem_t frame_data [FRAME_LEN];
    elem_t exp_q [$];
    string test_name;
    int    error_count = 0;
    int    test_err_base;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    done_count = 0;
    int    done_base;
    int    frame_out_cnt = 0;
    // cycles with in_valid high and in_ready low
    int    stall_count;
    // bound checker failures already counted
    int    assert_fail_seen = 0;

    swg_top swg_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .frame_done (frame_done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // output monitor sampling on the falling edge where outputs are stable
    always @(negedge clk) begin
        elem_t exp_val;
        if (!rst_n) begin
            frame_out_cnt = 0;
        end else begin
            if (out_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("%s produced output %h when none was expected", test_name, out_data);
                    error_count++;
                end
                if (exp_q.size() > 0) begin
                    exp_val = exp_q.pop_front();
                    assert (out_data === exp_val) else begin
                        $display("mismatch %s: expected %h actual %h", test_name, exp_val, out_data);
                        error_count++;
                    end
                end
                frame_out_cnt++;
            end
            // frame_done only with the last output of a frame
            assert (frame_done == (out_valid && frame_out_cnt == OUTS)) else begin
                $display("%s saw frame_done out of place after %0d outputs",
                         test_name, frame_out_cnt);
                error_count++;
            end
            if (frame_done) begin
                done_count++;
                frame_out_cnt = 0;
            end
        end
    end

    // watchdog sized from all frames of all tests
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        in_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        // whatever an aborted frame still owed is dropped
        exp_q.delete();
        rst_n <= 1'b1;
    endtask

    task automatic fill_ramp(input int offset);
        for (int i = 0; i < FRAME_LEN; i++) begin
            frame_data[i] = elem_t'(i + offset);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < FRAME_LEN; i++) begin
            frame_data[i] = elem_t'($random(seed));
        end
    endtask

    // im2col reference taking element (oh,ow,kh,kw,c) from pixel (oh+kh, ow+kw)
    task automatic expect_frame();
        for (int oh = 0; oh < OFM_H; oh++) begin
            for (int ow = 0; ow < OFM_W; ow++) begin
                for (int kh = 0; kh < `SWG_K; kh++) begin
                    for (int kw = 0; kw < `SWG_K; kw++) begin
                        for (int c = 0; c < `SWG_IFM_C; c++) begin
                            exp_q.push_back(frame_data[((oh + kh) * `SWG_IFM_W + ow + kw)
                                                       * `SWG_IFM_C + c]);
                        end
                    end
                end
            end
        end
    endtask

    // offer n elements held until accepted with random idle cycles in between
    task automatic send_elements(input int max_gap, input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            in_valid <= 1'b1;
            in_data <= frame_data[i];
            @(negedge clk);
            while (!in_ready) begin
                stall_count++;
                @(negedge clk);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int cycles;
        cycles = 0;
        while (done_count < done_base + n && cycles < FRAME_TIMEOUT * n) begin
            @(negedge clk);
            cycles++;
        end
        assert (done_count >= done_base + n) else begin
            $display("frame_done never came in %s after %0d cycles", test_name, cycles);
            error_count++;
        end
    endtask

    // fold failures of the bound checker into the error count
    task automatic collect_assertion_failures();
        int fails;
        fails = swg_top_i.swg_assertions_i.fail_count;
        if (fails > assert_fail_seen) begin
            $display("%s hit %0d concurrent assertion failures",
                     test_name, fails - assert_fail_seen);
            error_count += fails - assert_fail_seen;
            assert_fail_seen = fails;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err_base = error_count;
        done_base = done_count;
        stall_count = 0;
    endtask

    task automatic finish_test();
        @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%s ended with %0d expected outputs missing", test_name, exp_q.size());
            error_count++;
        end
        collect_assertion_failures();
        if (error_count == test_err_base) begin
            tests_passed++;
            $display("test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, error_count - test_err_base);
        end
    endtask

    task automatic stream_ramp_frame();
        start_test("ramp_frame");
        fill_ramp(0);
        expect_frame();
        send_elements(0, FRAME_LEN);
        wait_frames(1);
        finish_test();
    endtask

    task automatic send_gapped_random_frame();
        start_test("gapped_random_frame");
        fill_random();
        expect_frame();
        send_elements(MAX_GAP, FRAME_LEN);
        wait_frames(1);
        finish_test();
    endtask

    task automatic force_input_stall();
        start_test("input_stall_frame");
        fill_random();
        expect_frame();
        send_elements(0, FRAME_LEN);
        wait_frames(1);
        // writes outrun reads so the buffer must have filled up
        assert (stall_count > 0) else begin
            $display("in_ready never dropped in %s", test_name);
            error_count++;
        end
        finish_test();
    endtask

    task automatic chain_two_frames();
        start_test("back_to_back_frames");
        fill_ramp(128);
        expect_frame();
        send_elements(0, FRAME_LEN);
        // second frame is offered at once and waits on in_ready
        fill_random();
        expect_frame();
        send_elements(0, FRAME_LEN);
        wait_frames(2);
        finish_test();
    endtask

    task automatic reset_mid_frame();
        start_test("reset_mid_frame");
        fill_random();
        expect_frame();
        send_elements(0, FRAME_LEN / 2);
        // some windows are on their way out when reset hits
        repeat (20) @(posedge clk);
        apply_reset();
        repeat (20) begin
            @(negedge clk);
            assert (!out_valid && !frame_done && in_ready) else begin
                $display("%s shows output activity or a stalled input after reset", test_name);
                error_count++;
            end
        end
        fill_random();
        expect_frame();
        send_elements(0, FRAME_LEN);
        wait_frames(1);
        finish_test();
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        test_name = "reset";
        apply_reset();
        stream_ramp_frame();
        send_gapped_random_frame();
        force_input_stall();
        chain_two_frames();
        reset_mid_frame();
        collect_assertion_failures();
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/swg_pkg.sv
verilog/swg_controller.sv
verilog/swg_cyclic_buffer.sv
verilog/swg_scheduler.sv
verilog/swg_top.sv
dv/swg_assertions.sv
dv/swg_tb.sv

//--- Makefile
# Verilator flow for the sliding window generator

VERILATOR ?= verilator
TOP       ?= swg_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run passes only if the log holds no failure report
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || { echo "FAIL: no result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
